// File: Bender.yml
package:
  name: snoop_bus

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/snoop_pkg.sv
      - hdl/snoop_port_if.sv
      - hdl/snoop_bus.sv
      - hdl/snoop_cache_side.sv
      - hdl/snoop_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/snoop_chk.sv
      - sim/snoop_tb.sv

// File: hdl/snoop_bus.sv
`timescale 1ns/1ps
`include "snoop_params.svh"
`default_nettype none

module snoop_bus (
    input  logic                         clk,
    input  logic                         rst,

    snoop_port_if.bus                    ooo_port,
    snoop_port_if.bus                    ppl_port,

    output logic                         bus_ready,
    output snoop_pkg::snoop_resp_e       bus_resp,
    output snoop_pkg::bus_owner_e        bus_owner,

    output logic [`SNOOP_ADDR_BITS-1:0]  bus_command_address,
    output snoop_pkg::snoop_cmd_e        bus_command_command,
    output logic [`SNOOP_LINE_BITS-1:0]  bus_command_data,

    output logic [`SNOOP_ADDR_BITS-1:0]  bus_resp_address,
    output snoop_pkg::snoop_cmd_e        bus_resp_command,
    output logic [`SNOOP_LINE_BITS-1:0]  bus_resp_data
);

    typedef enum logic [2:0] {
        st_free,
        st_ooo_cmd,
        st_ooo_resp,
        st_ppl_cmd,
        st_ppl_resp
    } bus_state_e;

    bus_state_e                   state;
    bus_state_e                   state_next;

    // decoded phase of the current transaction
    logic                         cmd_phase;
    logic                         resp_phase;
    logic                         ppl_owns;

    // granted request and the peer's snoop answer
    logic [`SNOOP_ADDR_BITS-1:0]  grant_addr;
    snoop_pkg::snoop_cmd_e        grant_cmd;
    logic [`SNOOP_LINE_BITS-1:0]  grant_data;
    logic                         peer_hit;
    logic [`SNOOP_LINE_BITS-1:0]  peer_line;

    always_ff @(posedge clk) begin : state_reg
        if (rst) begin
            state <= st_free;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin : state_next_logic
        state_next = state;
        case (state)
            st_free: begin
                // ooo has fixed priority, ppl keeps its query up
                if (ooo_port.query) begin
                    state_next = st_ooo_cmd;
                end else if (ppl_port.query) begin
                    state_next = st_ppl_cmd;
                end
            end
            st_ooo_cmd:  state_next = st_ooo_resp;
            st_ooo_resp: state_next = st_free;
            st_ppl_cmd:  state_next = st_ppl_resp;
            st_ppl_resp: state_next = st_free;
            default:     state_next = st_free;
        endcase
    end

    assign cmd_phase  = (state == st_ooo_cmd) || (state == st_ppl_cmd);
    assign resp_phase = (state == st_ooo_resp) || (state == st_ppl_resp);
    assign ppl_owns   = (state == st_ppl_cmd) || (state == st_ppl_resp);

    // owner's request, other side's snoop answer
    assign grant_addr = ppl_owns ? ppl_port.addr : ooo_port.addr;
    assign grant_cmd  = ppl_owns ? ppl_port.cmd : ooo_port.cmd;
    assign grant_data = ppl_owns ? ppl_port.data : ooo_port.data;
    assign peer_hit   = ppl_owns ? ooo_port.snoop_hit : ppl_port.snoop_hit;
    assign peer_line  = ppl_owns ? ooo_port.snoop_line : ppl_port.snoop_line;

    assign bus_ready = (state == st_free);
    assign bus_owner = ppl_owns ? snoop_pkg::owner_ppl : snoop_pkg::owner_ooo;

    // snoop goes only to the non-owning side
    assign ppl_port.snoop_valid = (state == st_ooo_cmd);
    assign ppl_port.snoop_addr  = (state == st_ooo_cmd) ? ooo_port.addr : '0;
    assign ppl_port.snoop_cmd   = (state == st_ooo_cmd) ? ooo_port.cmd : snoop_pkg::read_shared;
    assign ppl_port.snoop_data  = (state == st_ooo_cmd) ? ooo_port.data : '0;

    assign ooo_port.snoop_valid = (state == st_ppl_cmd);
    assign ooo_port.snoop_addr  = (state == st_ppl_cmd) ? ppl_port.addr : '0;
    assign ooo_port.snoop_cmd   = (state == st_ppl_cmd) ? ppl_port.cmd : snoop_pkg::read_shared;
    assign ooo_port.snoop_data  = (state == st_ppl_cmd) ? ppl_port.data : '0;

    // release strobe to the owner
    assign ooo_port.done = (state == st_ooo_resp);
    assign ppl_port.done = (state == st_ppl_resp);

    always_comb begin : bus_outputs
        // idle values, zero command encodes as read_shared
        bus_command_address = '0;
        bus_command_command = snoop_pkg::read_shared;
        bus_command_data    = '0;
        bus_resp_address    = '0;
        bus_resp_command    = snoop_pkg::read_shared;
        bus_resp_data       = '0;
        bus_resp            = snoop_pkg::resp_none;

        // command stays visible through the response cycle
        if (cmd_phase || resp_phase) begin
            bus_command_address = grant_addr;
            bus_command_command = grant_cmd;
            bus_command_data    = grant_data;
        end

        if (resp_phase) begin
            bus_resp_address = grant_addr;
            bus_resp_command = grant_cmd;
            // line only when the peer actually hit
            bus_resp_data    = peer_hit ? peer_line : '0;
            bus_resp         = peer_hit ? snoop_pkg::resp_hit : snoop_pkg::resp_miss;
        end
    end

endmodule

`default_nettype wire

// File: hdl/snoop_cache_side.sv
`timescale 1ns/1ps
`include "snoop_params.svh"
`default_nettype none

module snoop_cache_side (
    input  logic                         clk,
    input  logic                         rst,

    snoop_port_if.cache                  port,

    input  logic                         req_valid,
    input  logic [`SNOOP_ADDR_BITS-1:0]  req_addr,
    input  snoop_pkg::snoop_cmd_e        req_cmd,
    input  logic [`SNOOP_LINE_BITS-1:0]  req_data,
    output logic                         req_busy,

    input  logic                         fill_valid,
    input  logic [`SNOOP_ADDR_BITS-1:0]  fill_addr,
    input  logic [`SNOOP_LINE_BITS-1:0]  fill_data
);

    // line store, one way per set
    logic [`SNOOP_TAG_BITS-1:0]   tag_q  [`SNOOP_SETS];
    logic [`SNOOP_LINE_BITS-1:0]  line_q [`SNOOP_SETS];
    logic [`SNOOP_SETS-1:0]       valid_q;

    // pending request
    logic                         busy_q;
    logic [`SNOOP_ADDR_BITS-1:0]  addr_q;
    snoop_pkg::snoop_cmd_e        cmd_q;
    logic [`SNOOP_LINE_BITS-1:0]  data_q;
    logic                         accept;

    // snoop lookup
    logic [`SNOOP_INDEX_BITS-1:0] snoop_index;
    logic [`SNOOP_TAG_BITS-1:0]   snoop_tag;
    logic                         snoop_match;
    logic                         hit_q;
    logic [`SNOOP_LINE_BITS-1:0]  hit_line_q;

    // fill target
    logic [`SNOOP_INDEX_BITS-1:0] fill_index;
    logic [`SNOOP_TAG_BITS-1:0]   fill_tag;

    // new pulse only taken while idle
    assign accept = req_valid && !busy_q;

    always_ff @(posedge clk) begin : req_ctrl
        if (rst) begin
            busy_q <= 1'b0;
        end else if (port.done) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin : req_payload
        if (accept) begin
            addr_q <= req_addr;
            cmd_q  <= req_cmd;
            data_q <= req_data;
        end
    end

    assign req_busy   = busy_q;
    assign port.query = busy_q;
    assign port.addr  = addr_q;
    assign port.cmd   = cmd_q;
    assign port.data  = data_q;

    // address split: tag | index | offset
    assign snoop_index = port.snoop_addr[`SNOOP_OFFSET_BITS +: `SNOOP_INDEX_BITS];
    assign snoop_tag   = port.snoop_addr[`SNOOP_ADDR_BITS-1 -: `SNOOP_TAG_BITS];
    assign snoop_match = valid_q[snoop_index] && (tag_q[snoop_index] == snoop_tag);

    assign fill_index = fill_addr[`SNOOP_OFFSET_BITS +: `SNOOP_INDEX_BITS];
    assign fill_tag   = fill_addr[`SNOOP_ADDR_BITS-1 -: `SNOOP_TAG_BITS];

    always_ff @(posedge clk) begin : line_store
        if (rst) begin
            valid_q <= '0;
            for (int i = 0; i < `SNOOP_SETS; i++) begin
                tag_q[i]  <= '0;
                line_q[i] <= '0;
            end
        end else begin
            // snoop side effects at the end of the command cycle
            if (port.snoop_valid && snoop_match) begin
                if (port.snoop_cmd == snoop_pkg::read_exclusive) begin
                    valid_q[snoop_index] <= 1'b0;
                end else if (port.snoop_cmd == snoop_pkg::write_update) begin
                    line_q[snoop_index] <= port.snoop_data;
                end
            end
            // external fill, never overlaps a snoop of this side
            if (fill_valid) begin
                valid_q[fill_index] <= 1'b1;
                tag_q[fill_index]   <= fill_tag;
                line_q[fill_index]  <= fill_data;
            end
        end
    end

    always_ff @(posedge clk) begin : snoop_hit_reg
        if (rst) begin
            hit_q <= 1'b0;
        end else if (port.snoop_valid) begin
            hit_q <= snoop_match;
        end
    end

    // old line, captured before any update lands
    always_ff @(posedge clk) begin : snoop_line_reg
        if (port.snoop_valid) begin
            hit_line_q <= line_q[snoop_index];
        end
    end

    assign port.snoop_hit  = hit_q;
    assign port.snoop_line = hit_line_q;

endmodule

`default_nettype wire

// File: hdl/snoop_pkg.sv
`default_nettype none

package snoop_pkg;

    // bus commands, same width for both cores
    typedef enum logic [2:0] {
        // snooped copy untouched
        read_shared    = 3'd0,
        // snooped copy dropped on a hit
        read_exclusive = 3'd1,
        // snooped copy takes the command data on a hit
        write_update   = 3'd2
    } snoop_cmd_e;

    // response code seen on bus_resp
    typedef enum logic [1:0] {
        // nothing this cycle
        resp_none = 2'd0,
        // other side held a valid copy
        resp_hit  = 2'd1,
        // other side had no copy
        resp_miss = 2'd2
    } snoop_resp_e;

    // which side owns the bus transaction
    typedef enum logic {
        owner_ooo = 1'b0,
        owner_ppl = 1'b1
    } bus_owner_e;

endpackage

`default_nettype wire

// File: hdl/snoop_port_if.sv
`timescale 1ns/1ps
`include "snoop_params.svh"
`default_nettype none

interface snoop_port_if;

    // request side, held by the cache until done
    logic                         query;
    logic [`SNOOP_ADDR_BITS-1:0]  addr;
    snoop_pkg::snoop_cmd_e        cmd;
    logic [`SNOOP_LINE_BITS-1:0]  data;

    // one-cycle strobe in this side's response cycle
    logic                         done;

    // snoop from the other side's request
    logic                         snoop_valid;
    logic [`SNOOP_ADDR_BITS-1:0]  snoop_addr;
    snoop_pkg::snoop_cmd_e        snoop_cmd;
    logic [`SNOOP_LINE_BITS-1:0]  snoop_data;

    // registered lookup result, valid in the response cycle
    logic                         snoop_hit;
    logic [`SNOOP_LINE_BITS-1:0]  snoop_line;

    modport cache (
        output query, addr, cmd, data, snoop_hit, snoop_line,
        input  done, snoop_valid, snoop_addr, snoop_cmd, snoop_data
    );

    modport bus (
        input  query, addr, cmd, data, snoop_hit, snoop_line,
        output done, snoop_valid, snoop_addr, snoop_cmd, snoop_data
    );

endinterface

`default_nettype wire

// File: hdl/snoop_top.sv
`timescale 1ns/1ps
`include "snoop_params.svh"
`default_nettype none

module snoop_top (
    input  logic                         clk,
    input  logic                         rst,

    // out-of-order core side
    input  logic                         ooo_req_valid,
    input  logic [`SNOOP_ADDR_BITS-1:0]  ooo_req_addr,
    input  snoop_pkg::snoop_cmd_e        ooo_req_cmd,
    input  logic [`SNOOP_LINE_BITS-1:0]  ooo_req_data,
    output logic                         ooo_req_busy,
    input  logic                         ooo_fill_valid,
    input  logic [`SNOOP_ADDR_BITS-1:0]  ooo_fill_addr,
    input  logic [`SNOOP_LINE_BITS-1:0]  ooo_fill_data,

    // in-order pipeline side
    input  logic                         ppl_req_valid,
    input  logic [`SNOOP_ADDR_BITS-1:0]  ppl_req_addr,
    input  snoop_pkg::snoop_cmd_e        ppl_req_cmd,
    input  logic [`SNOOP_LINE_BITS-1:0]  ppl_req_data,
    output logic                         ppl_req_busy,
    input  logic                         ppl_fill_valid,
    input  logic [`SNOOP_ADDR_BITS-1:0]  ppl_fill_addr,
    input  logic [`SNOOP_LINE_BITS-1:0]  ppl_fill_data,

    // bus status
    output logic                         bus_ready,
    output snoop_pkg::snoop_resp_e       bus_resp,
    output snoop_pkg::bus_owner_e        bus_owner,
    output logic [`SNOOP_ADDR_BITS-1:0]  bus_command_address,
    output snoop_pkg::snoop_cmd_e        bus_command_command,
    output logic [`SNOOP_LINE_BITS-1:0]  bus_command_data,
    output logic [`SNOOP_ADDR_BITS-1:0]  bus_resp_address,
    output snoop_pkg::snoop_cmd_e        bus_resp_command,
    output logic [`SNOOP_LINE_BITS-1:0]  bus_resp_data
);

    // one port bundle per cache
    snoop_port_if ooo_port ();
    snoop_port_if ppl_port ();

    snoop_cache_side u_ooo (
        .clk        (clk),
        .rst        (rst),
        .port       (ooo_port.cache),
        .req_valid  (ooo_req_valid),
        .req_addr   (ooo_req_addr),
        .req_cmd    (ooo_req_cmd),
        .req_data   (ooo_req_data),
        .req_busy   (ooo_req_busy),
        .fill_valid (ooo_fill_valid),
        .fill_addr  (ooo_fill_addr),
        .fill_data  (ooo_fill_data)
    );

    snoop_cache_side u_ppl (
        .clk        (clk),
        .rst        (rst),
        .port       (ppl_port.cache),
        .req_valid  (ppl_req_valid),
        .req_addr   (ppl_req_addr),
        .req_cmd    (ppl_req_cmd),
        .req_data   (ppl_req_data),
        .req_busy   (ppl_req_busy),
        .fill_valid (ppl_fill_valid),
        .fill_addr  (ppl_fill_addr),
        .fill_data  (ppl_fill_data)
    );

    // arbiter, ooo wins ties
    snoop_bus u_bus (
        .clk                 (clk),
        .rst                 (rst),
        .ooo_port            (ooo_port.bus),
        .ppl_port            (ppl_port.bus),
        .bus_ready           (bus_ready),
        .bus_resp            (bus_resp),
        .bus_owner           (bus_owner),
        .bus_command_address (bus_command_address),
        .bus_command_command (bus_command_command),
        .bus_command_data    (bus_command_data),
        .bus_resp_address    (bus_resp_address),
        .bus_resp_command    (bus_resp_command),
        .bus_resp_data       (bus_resp_data)
    );

endmodule

`default_nettype wire

// File: include/snoop_params.svh
`ifndef SNOOP_PARAMS_SVH
`define SNOOP_PARAMS_SVH

`default_nettype none

// byte address width on the bus
`define SNOOP_ADDR_BITS 32

// one cache line, 32 bytes
`define SNOOP_LINE_BITS 256

// byte offset within a line
`define SNOOP_OFFSET_BITS 5

// direct mapped, 16 sets
`define SNOOP_INDEX_BITS 4
`define SNOOP_SETS 16

// whatever is left above index and offset
`define SNOOP_TAG_BITS (`SNOOP_ADDR_BITS - `SNOOP_INDEX_BITS - `SNOOP_OFFSET_BITS)

`default_nettype wire

`endif

// File: sim/snoop_chk.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   ooo_query,
    input logic                   ppl_query,
    input logic                   ooo_done,
    input logic                   ppl_done,
    input logic                   bus_ready,
    input snoop_pkg::snoop_resp_e bus_resp
);

    // failed assertions so far, read by the testbench at the end
    int fail_count = 0;

    // only one owner released per cycle
    // released side still holds its query
    done_one_hot: assert property (@(posedge clk) disable iff (rst)
        !(ooo_done && ppl_done) && (ooo_query || !ooo_done) && (ppl_query || !ppl_done))
    else begin
        $error("done strobes overlap or reach a side without a query");
        fail_count++;
    end

    // grant while free, command cycle, then response cycle
    resp_two_after_grant: assert property (@(posedge clk) disable iff (rst)
        (bus_ready && (ooo_query || ppl_query)) |-> ##2 (bus_resp != snoop_pkg::resp_none))
    else begin
        $error("bus response missing two cycles after a grant");
        fail_count++;
    end

    // a response only while the bus is taken
    // bus free again one cycle later
    resp_while_busy: assert property (@(posedge clk) disable iff (rst)
        (bus_resp != snoop_pkg::resp_none) |-> !bus_ready ##1 bus_ready)
    else begin
        $error("bus response while free or bus not released after it");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: sim/snoop_tb.sv
`timescale 1ns/1ps
`include "snoop_params.svh"
`default_nettype none

module snoop_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int ROWS         = 20;

    // short names for the row table
    localparam snoop_pkg::bus_owner_e  side_o = snoop_pkg::owner_ooo;
    localparam snoop_pkg::bus_owner_e  side_p = snoop_pkg::owner_ppl;
    localparam snoop_pkg::snoop_cmd_e  c_rs   = snoop_pkg::read_shared;
    localparam snoop_pkg::snoop_cmd_e  c_rx   = snoop_pkg::read_exclusive;
    localparam snoop_pkg::snoop_cmd_e  c_wu   = snoop_pkg::write_update;
    localparam snoop_pkg::snoop_resp_e r_hit  = snoop_pkg::resp_hit;
    localparam snoop_pkg::snoop_resp_e r_miss = snoop_pkg::resp_miss;

    // a pair row is the ooo half, the next row its ppl half
    typedef enum logic [1:0] {op_fill, op_single, op_pair} op_e;

    typedef struct packed {
        op_e                          op;
        snoop_pkg::bus_owner_e        side;
        logic [`SNOOP_ADDR_BITS-1:0]  addr;
        snoop_pkg::snoop_cmd_e        cmd;
        logic [`SNOOP_LINE_BITS-1:0]  data;
        snoop_pkg::snoop_resp_e       exp_resp;
        logic [`SNOOP_LINE_BITS-1:0]  exp_data;
    } row_t;

    logic                         clk;
    logic                         rst;
    logic                         ooo_req_valid;
    logic [`SNOOP_ADDR_BITS-1:0]  ooo_req_addr;
    snoop_pkg::snoop_cmd_e        ooo_req_cmd;
    logic [`SNOOP_LINE_BITS-1:0]  ooo_req_data;
    logic                         ooo_req_busy;
    logic                         ooo_fill_valid;
    logic [`SNOOP_ADDR_BITS-1:0]  ooo_fill_addr;
    logic [`SNOOP_LINE_BITS-1:0]  ooo_fill_data;
    logic                         ppl_req_valid;
    logic [`SNOOP_ADDR_BITS-1:0]  ppl_req_addr;
    snoop_pkg::snoop_cmd_e        ppl_req_cmd;
    logic [`SNOOP_LINE_BITS-1:0]  ppl_req_data;
    logic                         ppl_req_busy;
    logic                         ppl_fill_valid;
    logic [`SNOOP_ADDR_BITS-1:0]  ppl_fill_addr;
    logic [`SNOOP_LINE_BITS-1:0]  ppl_fill_data;
    logic                         bus_ready;
    snoop_pkg::snoop_resp_e       bus_resp;
    snoop_pkg::bus_owner_e        bus_owner;
    logic [`SNOOP_ADDR_BITS-1:0]  bus_command_address;
    snoop_pkg::snoop_cmd_e        bus_command_command;
    logic [`SNOOP_LINE_BITS-1:0]  bus_command_data;
    logic [`SNOOP_ADDR_BITS-1:0]  bus_resp_address;
    snoop_pkg::snoop_cmd_e        bus_resp_command;
    logic [`SNOOP_LINE_BITS-1:0]  bus_resp_data;

    row_t                         rows [ROWS];
    int                           n_rows = 0;
    int                           seed = 63452;

    // reference store per side, index 0 is ooo
    logic                         m_valid [2][`SNOOP_SETS];
    logic [`SNOOP_TAG_BITS-1:0]   m_tag   [2][`SNOOP_SETS];
    logic [`SNOOP_LINE_BITS-1:0]  m_line  [2][`SNOOP_SETS];

    snoop_top DUT (.*);

    // bus checker sits inside the arbiter
    bind snoop_bus snoop_chk u_chk (
        .clk       (clk),
        .rst       (rst),
        .ooo_query (ooo_port.query),
        .ppl_query (ppl_port.query),
        .ooo_done  (ooo_port.done),
        .ppl_done  (ppl_port.done),
        .bus_ready (bus_ready),
        .bus_resp  (bus_resp)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #((ROWS * 8 + RESET_CYCLES) * CLK_PERIOD);
        $display("Run timed out, the bus never answered a request");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report_fail();
        $display("Checks failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_resp(input string name, input snoop_pkg::snoop_resp_e got,
                              input snoop_pkg::snoop_resp_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %s (%0d) expected %s (%0d)", $time, name,
                     got.name(), got, exp.name(), exp);
            report_fail();
        end
    endtask

    task automatic check_cmd(input string name, input snoop_pkg::snoop_cmd_e got,
                             input snoop_pkg::snoop_cmd_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %s (%0d) expected %s (%0d)", $time, name,
                     got.name(), got, exp.name(), exp);
            report_fail();
        end
    endtask

    task automatic check_owner(input string name, input snoop_pkg::bus_owner_e got,
                               input snoop_pkg::bus_owner_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            report_fail();
        end
    endtask

    // addresses come in zero extended
    task automatic check_word(input string name, input logic [`SNOOP_LINE_BITS-1:0] got,
                              input logic [`SNOOP_LINE_BITS-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            report_fail();
        end
    endtask

    function automatic logic [`SNOOP_LINE_BITS-1:0] random_line();
        logic [`SNOOP_LINE_BITS-1:0] line;
        for (int k = 0; k < `SNOOP_LINE_BITS / 32; k++) begin
            line[k*32 +: 32] = $random(seed);
        end
        return line;
    endfunction

    task automatic add_row(input op_e op, input snoop_pkg::bus_owner_e side,
                           input logic [`SNOOP_ADDR_BITS-1:0] addr,
                           input snoop_pkg::snoop_cmd_e cmd,
                           input snoop_pkg::snoop_resp_e exp_resp);
        rows[n_rows].op       = op;
        rows[n_rows].side     = side;
        rows[n_rows].addr     = addr;
        rows[n_rows].cmd      = cmd;
        rows[n_rows].data     = random_line();
        rows[n_rows].exp_resp = exp_resp;
        rows[n_rows].exp_data = '0;
        n_rows++;
    endtask

    // sets: 0x1040/0x3040 -> 2, 0x2100 -> 8, 0x4180 -> 12, 0x51c0 -> 14, 0x61e0 -> 15
    task automatic build_rows();
        add_row(op_single, side_o, 32'h0000_1040, c_rs, r_miss);
        add_row(op_single, side_p, 32'h0000_7000, c_rx, r_miss);
        add_row(op_single, side_o, 32'h0000_7020, c_wu, r_miss);
        add_row(op_fill,   side_p, 32'h0000_1040, c_rs, r_miss);
        add_row(op_single, side_o, 32'h0000_1040, c_rs, r_hit);
        add_row(op_single, side_o, 32'h0000_1040, c_rs, r_hit);
        // same set, other tag
        add_row(op_single, side_o, 32'h0000_3040, c_rs, r_miss);
        add_row(op_fill,   side_o, 32'h0000_2100, c_rs, r_miss);
        add_row(op_single, side_p, 32'h0000_2100, c_rx, r_hit);
        add_row(op_single, side_p, 32'h0000_2100, c_rs, r_miss);
        add_row(op_fill,   side_o, 32'h0000_4180, c_rs, r_miss);
        // update returns the old line, the read after sees the new one
        add_row(op_single, side_p, 32'h0000_4180, c_wu, r_hit);
        add_row(op_single, side_p, 32'h0000_4180, c_rs, r_hit);
        add_row(op_fill,   side_p, 32'h0000_51c0, c_rs, r_miss);
        add_row(op_fill,   side_o, 32'h0000_61e0, c_rs, r_miss);
        add_row(op_pair,   side_o, 32'h0000_51c0, c_rs, r_hit);
        add_row(op_pair,   side_p, 32'h0000_61e0, c_rx, r_hit);
        add_row(op_single, side_p, 32'h0000_61e0, c_rs, r_miss);
        add_row(op_pair,   side_o, 32'h0000_1040, c_rx, r_hit);
        add_row(op_pair,   side_p, 32'h0000_7000, c_wu, r_miss);
    endtask

    // walk the rows in service order, fill in the expected line
    task automatic predict_rows();
        int                         s;
        int                         p;
        int                         idx;
        logic [`SNOOP_TAG_BITS-1:0] tag;
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < `SNOOP_SETS; j++) begin
                m_valid[i][j] = 1'b0;
            end
        end
        for (int r = 0; r < n_rows; r++) begin
            s   = (rows[r].side == snoop_pkg::owner_ppl) ? 1 : 0;
            p   = 1 - s;
            idx = rows[r].addr[`SNOOP_OFFSET_BITS +: `SNOOP_INDEX_BITS];
            tag = rows[r].addr[`SNOOP_ADDR_BITS-1 -: `SNOOP_TAG_BITS];
            if (rows[r].op == op_fill) begin
                m_valid[s][idx] = 1'b1;
                m_tag[s][idx]   = tag;
                m_line[s][idx]  = rows[r].data;
            end else if (m_valid[p][idx] && (m_tag[p][idx] == tag)) begin
                rows[r].exp_data = m_line[p][idx];
                if (rows[r].cmd == snoop_pkg::read_exclusive) begin
                    m_valid[p][idx] = 1'b0;
                end else if (rows[r].cmd == snoop_pkg::write_update) begin
                    m_line[p][idx] = rows[r].data;
                end
            end
        end
    endtask

    task automatic drive_request(input row_t row);
        if (row.side == snoop_pkg::owner_ooo) begin
            ooo_req_valid <= 1'b1;
            ooo_req_addr  <= row.addr;
            ooo_req_cmd   <= row.cmd;
            ooo_req_data  <= row.data;
        end else begin
            ppl_req_valid <= 1'b1;
            ppl_req_addr  <= row.addr;
            ppl_req_cmd   <= row.cmd;
            ppl_req_data  <= row.data;
        end
    endtask

    task automatic drive_fill(input row_t row);
        if (row.side == snoop_pkg::owner_ooo) begin
            ooo_fill_valid <= 1'b1;
            ooo_fill_addr  <= row.addr;
            ooo_fill_data  <= row.data;
        end else begin
            ppl_fill_valid <= 1'b1;
            ppl_fill_addr  <= row.addr;
            ppl_fill_data  <= row.data;
        end
    endtask

    task automatic drop_strobes();
        ooo_req_valid  <= 1'b0;
        ppl_req_valid  <= 1'b0;
        ooo_fill_valid <= 1'b0;
        ppl_fill_valid <= 1'b0;
    endtask

    // sample at the falling edge, away from the drives
    task automatic wait_response();
        @(negedge clk);
        while (bus_resp == snoop_pkg::resp_none) begin
            @(negedge clk);
        end
    endtask

    task automatic check_row(input row_t row);
        check_resp("bus_resp", bus_resp, row.exp_resp);
        check_owner("bus_owner", bus_owner, row.side);
        check_word("bus_resp_address", bus_resp_address, row.addr);
        check_cmd("bus_resp_command", bus_resp_command, row.cmd);
        check_word("bus_resp_data", bus_resp_data, row.exp_data);
        check_word("bus_command_address", bus_command_address, row.addr);
        check_cmd("bus_command_command", bus_command_command, row.cmd);
        check_word("bus_command_data", bus_command_data, row.data);
    endtask

    initial begin : stimulus
        int r;
        rst            = 1'b1;
        ooo_req_valid  = 1'b0;
        ooo_req_addr   = '0;
        ooo_req_cmd    = snoop_pkg::read_shared;
        ooo_req_data   = '0;
        ooo_fill_valid = 1'b0;
        ooo_fill_addr  = '0;
        ooo_fill_data  = '0;
        ppl_req_valid  = 1'b0;
        ppl_req_addr   = '0;
        ppl_req_cmd    = snoop_pkg::read_shared;
        ppl_req_data   = '0;
        ppl_fill_valid = 1'b0;
        ppl_fill_addr  = '0;
        ppl_fill_data  = '0;
        build_rows();
        predict_rows();

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // idle state straight out of reset
        @(negedge clk);
        check_flag("bus_ready", bus_ready, 1'b1);
        check_resp("bus_resp", bus_resp, snoop_pkg::resp_none);
        check_flag("ooo_req_busy", ooo_req_busy, 1'b0);
        check_flag("ppl_req_busy", ppl_req_busy, 1'b0);

        r = 0;
        while (r < n_rows) begin
            @(posedge clk);
            case (rows[r].op)
                op_fill: begin
                    drive_fill(rows[r]);
                    @(posedge clk);
                    drop_strobes();
                    r = r + 1;
                end
                op_single: begin
                    drive_request(rows[r]);
                    @(posedge clk);
                    drop_strobes();
                    wait_response();
                    check_row(rows[r]);
                    r = r + 1;
                end
                default: begin
                    // both pulses on one edge, ooo answered first
                    drive_request(rows[r]);
                    drive_request(rows[r+1]);
                    @(posedge clk);
                    drop_strobes();
                    wait_response();
                    check_row(rows[r]);
                    wait_response();
                    check_row(rows[r+1]);
                    r = r + 2;
                end
            endcase
        end

        // release of the last response lands one edge later
        repeat (2) @(negedge clk);
        if (DUT.u_bus.u_chk.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "bus assertions fired");
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hdl/snoop_pkg.sv
hdl/snoop_port_if.sv
hdl/snoop_bus.sv
hdl/snoop_cache_side.sv
hdl/snoop_top.sv
sim/snoop_chk.sv
sim/snoop_tb.sv
